// ==== hdl/mem_pkg.sv ====
package mem_pkg;

  // Access width on the bus
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } size_e;

  // Request from the core, held stable until the response
  typedef struct packed {
    logic        valid;  // One-cycle pulse
    logic        write;  // High for a store
    size_e       size;
    logic [31:0] addr;
    logic [31:0] wdata;  // Zero-extended, no lane shifting
  } bus_req_t;

  // Response from memory
  typedef struct packed {
    logic        valid;  // One-cycle pulse
    logic [31:0] rdata;  // Four bytes from addr, little endian
  } bus_rsp_t;

endpackage

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

  // Operations the core understands
  typedef enum logic [3:0] {
    OP_LB   = 4'd0,
    OP_LH   = 4'd1,
    OP_LW   = 4'd2,
    OP_LBU  = 4'd3,
    OP_LHU  = 4'd4,
    OP_SB   = 4'd5,
    OP_SH   = 4'd6,
    OP_SW   = 4'd7,
    OP_ADDI = 4'd8,
    OP_NOP  = 4'd9
  } op_e;

  typedef enum logic {
    PH_FETCH = 1'b0,
    PH_EXEC  = 1'b1
  } phase_e;

  typedef struct packed {
    op_e         op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;  // I-type, or S-type for stores
  } decoded_t;

  // Load/store unit result
  typedef struct packed {
    logic        valid;  // One-cycle pulse
    logic [31:0] data;   // Fetched word, extended load or zero
  } ls_result_t;

endpackage

// ==== hdl/insn_decoder.sv ====
module insn_decoder (
  input  logic [31:0]       i_ir,
  output isa_pkg::decoded_t o_dec
);
  import isa_pkg::*;

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  op_e         op;

  assign opcode = i_ir[6:0];
  assign funct3 = i_ir[14:12];
  assign rd     = i_ir[11:7];
  assign imm_i  = {{20{i_ir[31]}}, i_ir[31:20]};
  assign imm_s  = {{20{i_ir[31]}}, i_ir[31:25], i_ir[11:7]};

  always_comb begin
    op = OP_NOP;
    case (opcode)
      OPC_LOAD: begin
        case (funct3)
          3'b000:  op = OP_LB;
          3'b001:  op = OP_LH;
          3'b010:  op = OP_LW;
          3'b100:  op = OP_LBU;
          3'b101:  op = OP_LHU;
          default: op = OP_NOP;
        endcase
      end
      OPC_STORE: begin
        case (funct3)
          3'b000:  op = OP_SB;
          3'b001:  op = OP_SH;
          3'b010:  op = OP_SW;
          default: op = OP_NOP;
        endcase
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000 && rd != 5'd0) begin  // addi x0 is the canonical NOP
          op = OP_ADDI;
        end
      end
      default: op = OP_NOP;
    endcase
  end

  assign o_dec.op  = op;
  assign o_dec.rd  = rd;
  assign o_dec.rs1 = i_ir[19:15];
  assign o_dec.rs2 = i_ir[24:20];
  assign o_dec.imm = (opcode == OPC_STORE) ? imm_s : imm_i;

endmodule

// ==== hdl/reg_file.sv ====
module reg_file (
  input  logic        i_clk,
  input  logic        i_arst_n,
  input  logic [4:0]  i_rs1_idx,
  input  logic [4:0]  i_rs2_idx,
  input  logic        i_we,
  input  logic [4:0]  i_rd_idx,
  input  logic [31:0] i_rd_data,
  output logic [31:0] o_rs1_val,
  output logic [31:0] o_rs2_val
);

  logic [31:0] regs [32];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd_idx != 5'd0) begin  // x0 never written
      regs[i_rd_idx] <= i_rd_data;
    end
  end

  // Asynchronous reads
  assign o_rs1_val = regs[i_rs1_idx];
  assign o_rs2_val = regs[i_rs2_idx];

  // x0 reads zero whatever the write history
  a_x0_reads_zero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_rs1_idx == 5'd0) |-> (o_rs1_val == 32'd0));

endmodule

// ==== hdl/load_store.sv ====
module load_store (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_start,
  input  isa_pkg::phase_e     i_phase,
  input  isa_pkg::op_e        i_op,
  input  logic [31:0]         i_imm,
  input  logic [31:0]         i_pc,
  input  logic [31:0]         i_rs1_val,
  input  logic [31:0]         i_rs2_val,
  output mem_pkg::bus_req_t   o_req,
  input  mem_pkg::bus_rsp_t   i_rsp,
  output isa_pkg::ls_result_t o_result
);
  import mem_pkg::*;
  import isa_pkg::*;

  typedef enum logic {
    LS_READY   = 1'b0,
    LS_WAITING = 1'b1
  } ls_state_e;

  ls_state_e   state;
  logic        req_valid;
  logic        req_write;
  size_e       req_size;
  logic [31:0] req_addr;
  logic [31:0] req_wdata;
  op_e         pend_op;     // Access awaiting its response
  logic        pend_fetch;  // Pending access is an instruction fetch
  logic        res_valid;
  logic [31:0] res_data;
  logic        is_store;
  size_e       acc_size;
  logic [31:0] store_data;
  logic [31:0] load_data;

  assign is_store = (i_op == OP_SB) || (i_op == OP_SH) || (i_op == OP_SW);

  always_comb begin
    case (i_op)
      OP_LB, OP_LBU, OP_SB: acc_size = SZ_BYTE;
      OP_LH, OP_LHU, OP_SH: acc_size = SZ_HALF;
      default:              acc_size = SZ_WORD;
    endcase
  end

  always_comb begin
    case (i_op)
      OP_SB:   store_data = {24'd0, i_rs2_val[7:0]};   // Low byte only
      OP_SH:   store_data = {16'd0, i_rs2_val[15:0]};  // Low half only
      default: store_data = i_rs2_val;
    endcase
  end

  // Extension of the returned bytes
  always_comb begin
    if (pend_fetch) begin
      load_data = i_rsp.rdata;
    end else begin
      case (pend_op)
        OP_LB:   load_data = {{24{i_rsp.rdata[7]}}, i_rsp.rdata[7:0]};
        OP_LH:   load_data = {{16{i_rsp.rdata[15]}}, i_rsp.rdata[15:0]};
        OP_LBU:  load_data = {24'd0, i_rsp.rdata[7:0]};
        OP_LHU:  load_data = {16'd0, i_rsp.rdata[15:0]};
        OP_LW:   load_data = i_rsp.rdata;
        default: load_data = 32'd0;  // Stores return nothing
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state     <= LS_READY;
      req_valid <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      req_valid <= 1'b0;
      res_valid <= 1'b0;
      case (state)
        LS_READY: begin
          if (i_start) begin
            req_valid <= 1'b1;  // Request one cycle after start
            state     <= LS_WAITING;
          end
        end
        LS_WAITING: begin
          if (i_rsp.valid) begin
            res_valid <= 1'b1;
            state     <= LS_READY;
          end
        end
        default: state <= LS_READY;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == LS_READY && i_start) begin
      pend_op    <= i_op;
      pend_fetch <= (i_phase == PH_FETCH);
      if (i_phase == PH_FETCH) begin
        req_write <= 1'b0;
        req_size  <= SZ_WORD;
        req_addr  <= i_pc;
        req_wdata <= 32'd0;
      end else begin
        req_write <= is_store;
        req_size  <= acc_size;
        req_addr  <= i_rs1_val + i_imm;
        req_wdata <= is_store ? store_data : 32'd0;
      end
    end
    if (state == LS_WAITING && i_rsp.valid) begin
      res_data <= load_data;
    end
  end

  assign o_req.valid     = req_valid;
  assign o_req.write     = req_write;
  assign o_req.size      = req_size;
  assign o_req.addr      = req_addr;
  assign o_req.wdata     = req_wdata;
  assign o_result.valid  = res_valid;
  assign o_result.data   = res_data;

  // The sequencer waits for each result before the next start
  a_no_start_waiting: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_start |-> (state == LS_READY));

  // Memory answers only an outstanding request
  a_no_rsp_ready: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_rsp.valid |-> (state == LS_WAITING));

endmodule

// ==== hdl/core_sequencer.sv ====
module core_sequencer #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  isa_pkg::decoded_t   i_dec,
  input  logic [31:0]         i_rs1_val,
  input  isa_pkg::ls_result_t i_result,
  output isa_pkg::phase_e     o_phase,
  output logic [31:0]         o_ir,
  output logic [31:0]         o_pc,
  output logic                o_start,
  output logic                o_rf_we,
  output logic [4:0]          o_rf_rd,
  output logic [31:0]         o_rf_data
);
  import isa_pkg::*;

  phase_e      phase;
  logic [31:0] pc;
  logic [31:0] ir;
  logic        boot;         // First cycle out of reset
  logic        fetch_start;  // Start pulse for the next fetch
  logic        exec_first;   // First cycle of EXEC
  logic        is_load;
  logic        is_mem;
  logic        retire_now;   // ADDI and NOP finish in one cycle
  logic        mem_done;

  assign is_load = (i_dec.op == OP_LB) || (i_dec.op == OP_LH) || (i_dec.op == OP_LW) ||
                   (i_dec.op == OP_LBU) || (i_dec.op == OP_LHU);
  assign is_mem  = is_load || (i_dec.op == OP_SB) || (i_dec.op == OP_SH) ||
                   (i_dec.op == OP_SW);

  assign retire_now = (phase == PH_EXEC) && exec_first && !is_mem;
  assign mem_done   = (phase == PH_EXEC) && i_result.valid;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      phase       <= PH_FETCH;
      pc          <= RESET_PC;
      boot        <= 1'b1;
      fetch_start <= 1'b0;
      exec_first  <= 1'b0;
    end else begin
      boot        <= 1'b0;
      fetch_start <= boot;
      exec_first  <= 1'b0;
      if (phase == PH_FETCH && i_result.valid) begin
        phase      <= PH_EXEC;
        exec_first <= 1'b1;
      end else if (retire_now || mem_done) begin
        phase       <= PH_FETCH;
        pc          <= pc + 32'd4;
        fetch_start <= 1'b1;  // Next fetch right after entry
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (phase == PH_FETCH && i_result.valid) begin
      ir <= i_result.data;
    end
  end

  assign o_start   = fetch_start || (phase == PH_EXEC && exec_first && is_mem);
  assign o_rf_we   = (retire_now && i_dec.op == OP_ADDI) || (mem_done && is_load);
  assign o_rf_rd   = i_dec.rd;
  assign o_rf_data = (i_dec.op == OP_ADDI) ? i_rs1_val + i_dec.imm : i_result.data;
  assign o_phase   = phase;
  assign o_ir      = ir;
  assign o_pc      = pc;

  // Holds only for an aligned RESET_PC from the top
  a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    pc[1:0] == 2'b00);

endmodule

// ==== hdl/rv_ls_core.sv ====
module rv_ls_core #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic              i_clk,
  input  logic              i_arst_n,
  output mem_pkg::bus_req_t o_req,
  input  mem_pkg::bus_rsp_t i_rsp
);
  import isa_pkg::*;

  decoded_t    dec;
  phase_e      phase;
  ls_result_t  result;
  logic [31:0] ir;
  logic [31:0] pc;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic        start;
  logic        rf_we;
  logic [4:0]  rf_rd;
  logic [31:0] rf_data;

  insn_decoder u_decoder (
    .i_ir  (ir),
    .o_dec (dec)
  );

  reg_file u_reg_file (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_rs1_idx (dec.rs1),
    .i_rs2_idx (dec.rs2),
    .i_we      (rf_we),
    .i_rd_idx  (rf_rd),
    .i_rd_data (rf_data),
    .o_rs1_val (rs1_val),
    .o_rs2_val (rs2_val)
  );

  load_store u_load_store (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_start   (start),
    .i_phase   (phase),
    .i_op      (dec.op),
    .i_imm     (dec.imm),
    .i_pc      (pc),
    .i_rs1_val (rs1_val),
    .i_rs2_val (rs2_val),
    .o_req     (o_req),
    .i_rsp     (i_rsp),
    .o_result  (result)
  );

  core_sequencer #(
    .RESET_PC (RESET_PC)
  ) u_sequencer (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_dec     (dec),
    .i_rs1_val (rs1_val),
    .i_result  (result),
    .o_phase   (phase),
    .o_ir      (ir),
    .o_pc      (pc),
    .o_start   (start),
    .o_rf_we   (rf_we),
    .o_rf_rd   (rf_rd),
    .o_rf_data (rf_data)
  );

endmodule

// ==== test/tb_rv_ls_core.sv ====
module tb_rv_ls_core;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;

  localparam logic [31:0] START_PC = 32'h100;
  localparam int CYCLE_LIMIT = 2000;  // 6 tests x 20 insns x 14 cycles, plus margin
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  logic        clk;
  logic        arst_n;
  bus_req_t    req;
  bus_rsp_t    rsp;
  logic [7:0]  mem [4096];
  bus_req_t    all_reqs [$];  // Every request in order
  bus_req_t    stores [$];    // Write requests only
  logic [31:0] prog [$];
  logic [31:0] end_pc;        // Fetch here marks the last retirement
  logic        end_seen;
  logic        rand_delay;
  logic        busy;
  int          wait_cnt;
  bus_req_t    cur;
  int          cycles = 0;
  string       test_name;

  rv_ls_core #(
    .RESET_PC (START_PC)
  ) i_rv_ls_core (
    .i_clk    (clk),
    .i_arst_n (arst_n),
    .o_req    (req),
    .i_rsp    (rsp)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout, the program did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  function automatic logic [7:0] get_byte(input logic [31:0] a);
    return mem[a[11:0]];
  endfunction

  task automatic put_byte(input logic [31:0] a, input logic [7:0] d);
    mem[a[11:0]] = d;
  endtask

  task automatic put_word(input logic [31:0] a, input logic [31:0] d);
    put_byte(a, d[7:0]);
    put_byte(a + 32'd1, d[15:8]);
    put_byte(a + 32'd2, d[23:16]);
    put_byte(a + 32'd3, d[31:24]);
  endtask

  function automatic int pick_delay();
    return rand_delay ? int'($urandom_range(5, 0)) : 1;
  endfunction

  // Completes the held request, little endian
  task automatic respond(input bus_req_t r);
    rsp.rdata = 32'd0;
    if (r.write) begin
      put_byte(r.addr, r.wdata[7:0]);
      if (r.size != SZ_BYTE) begin
        put_byte(r.addr + 32'd1, r.wdata[15:8]);
      end
      if (r.size == SZ_WORD) begin
        put_byte(r.addr + 32'd2, r.wdata[23:16]);
        put_byte(r.addr + 32'd3, r.wdata[31:24]);
      end
    end else begin
      rsp.rdata = {get_byte(r.addr + 32'd3), get_byte(r.addr + 32'd2),
                   get_byte(r.addr + 32'd1), get_byte(r.addr)};
    end
    rsp.valid = 1'b1;
  endtask

  // Memory model, one access at a time
  initial begin
    busy     = 1'b0;
    wait_cnt = 0;
    end_seen = 1'b0;
    forever begin
      @(negedge clk);
      rsp.valid = 1'b0;
      if (!arst_n) begin
        busy = 1'b0;
      end else if (busy) begin
        check_eq("request while busy", 32'd0, 32'(req.valid));
        if (wait_cnt == 0) begin
          respond(cur);
          busy = 1'b0;
        end else begin
          wait_cnt--;
        end
      end else if (req.valid) begin
        cur      = req;
        busy     = 1'b1;
        wait_cnt = pick_delay();
        all_reqs.push_back(req);
        if (req.write) begin
          stores.push_back(req);
        end else if (req.addr == end_pc) begin
          end_seen = 1'b1;
        end
      end
    end
  end

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return enc_i(7'b0010011, 3'b000, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
    return enc_i(7'b0000011, f3, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "Mismatch in %s", test_name);
    end
  endtask

  task automatic check_store(input int idx, input logic [31:0] addr, input size_e size,
                             input logic [31:0] data);
    check_eq("store addr", addr, stores[idx].addr);
    check_eq("store size", 32'(size), 32'(stores[idx].size));
    check_eq("store data", data, stores[idx].wdata);
  endtask

  task automatic check_load(input int idx, input logic [31:0] addr, input size_e size);
    check_eq("load write", 32'd0, 32'(all_reqs[idx].write));
    check_eq("load addr", addr, all_reqs[idx].addr);
    check_eq("load size", 32'(size), 32'(all_reqs[idx].size));
  endtask

  // Reset the DUT and clear the model
  task automatic start_test(input string name, input logic use_rand);
    @(negedge clk);
    arst_n = 1'b0;
    @(negedge clk);
    test_name  = name;
    rand_delay = use_rand;
    end_seen   = 1'b0;
    all_reqs.delete();
    stores.delete();
    prog.delete();
    for (int a = 0; a < 4096; a++) begin
      mem[12'(a)] = 8'h00;
    end
  endtask

  task automatic run_program();
    for (int i = 0; i < prog.size(); i++) begin
      put_word(START_PC + 32'(4 * i), prog[i]);
    end
    end_pc = START_PC + 32'(4 * prog.size());
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    while (!end_seen) begin
      @(negedge clk);
    end
  endtask

  task automatic test_fetch_sequence();
    start_test("fetch_sequence", 1'b0);
    prog.push_back(enc_addi(5'd0, 5'd0, 12'd0));
    prog.push_back(enc_addi(5'd1, 5'd0, 12'd5));
    prog.push_back(enc_addi(5'd0, 5'd0, 12'd0));
    prog.push_back(enc_addi(5'd2, 5'd1, 12'd7));
    prog.push_back(enc_addi(5'd3, 5'd2, 12'hFFF));  // -1
    prog.push_back(enc_addi(5'd0, 5'd0, 12'd0));
    run_program();
    check_eq("request count", 32'd7, 32'(all_reqs.size()));
    for (int i = 0; i < 7; i++) begin
      check_eq("fetch addr", START_PC + 32'(4 * i), all_reqs[i].addr);
      check_eq("fetch write", 32'd0, 32'(all_reqs[i].write));
      check_eq("fetch size", 32'(SZ_WORD), 32'(all_reqs[i].size));
    end
  endtask

  task automatic test_addi_store();
    start_test("addi_store", 1'b0);
    prog.push_back(enc_addi(5'd1, 5'd0, 12'h300));
    prog.push_back(enc_addi(5'd2, 5'd0, 12'hFFB));         // -5
    prog.push_back(enc_store(F3_W, 5'd2, 5'd1, 12'd8));
    prog.push_back(enc_store(F3_W, 5'd2, 5'd1, 12'hFF0));  // -16
    prog.push_back(enc_addi(5'd3, 5'd1, 12'h7FF));
    prog.push_back(enc_store(F3_W, 5'd3, 5'd1, 12'hFFF));  // -1
    run_program();
    check_eq("store count", 32'd3, 32'(stores.size()));
    check_store(0, 32'h308, SZ_WORD, 32'hFFFF_FFFB);
    check_store(1, 32'h2F0, SZ_WORD, 32'hFFFF_FFFB);
    check_store(2, 32'h2FF, SZ_WORD, 32'h0000_0AFF);
  endtask

  task automatic test_load_extend();
    start_test("load_extend", 1'b0);
    put_byte(32'h200, 8'h80);
    put_byte(32'h201, 8'h7F);
    put_byte(32'h204, 8'h01);
    put_byte(32'h205, 8'h80);
    put_word(32'h208, 32'h8765_4321);
    prog.push_back(enc_addi(5'd1, 5'd0, 12'h200));
    prog.push_back(enc_load(F3_B, 5'd2, 5'd1, 12'd0));
    prog.push_back(enc_store(F3_W, 5'd2, 5'd1, 12'd64));
    prog.push_back(enc_load(F3_BU, 5'd3, 5'd1, 12'd0));
    prog.push_back(enc_store(F3_W, 5'd3, 5'd1, 12'd68));
    prog.push_back(enc_load(F3_B, 5'd4, 5'd1, 12'd1));
    prog.push_back(enc_store(F3_W, 5'd4, 5'd1, 12'd72));
    prog.push_back(enc_load(F3_H, 5'd5, 5'd1, 12'd4));
    prog.push_back(enc_store(F3_W, 5'd5, 5'd1, 12'd76));
    prog.push_back(enc_load(F3_HU, 5'd6, 5'd1, 12'd4));
    prog.push_back(enc_store(F3_W, 5'd6, 5'd1, 12'd80));
    prog.push_back(enc_load(F3_W, 5'd7, 5'd1, 12'd8));
    prog.push_back(enc_store(F3_W, 5'd7, 5'd1, 12'd84));
    run_program();
    check_eq("store count", 32'd6, 32'(stores.size()));
    check_store(0, 32'h240, SZ_WORD, 32'hFFFF_FF80);  // Sign of bit 7
    check_store(1, 32'h244, SZ_WORD, 32'h0000_0080);
    check_store(2, 32'h248, SZ_WORD, 32'h0000_007F);
    check_store(3, 32'h24C, SZ_WORD, 32'hFFFF_8001);  // Sign of bit 15
    check_store(4, 32'h250, SZ_WORD, 32'h0000_8001);
    check_store(5, 32'h254, SZ_WORD, 32'h8765_4321);
    check_eq("request count", 32'd26, 32'(all_reqs.size()));
    check_load(2, 32'h200, SZ_BYTE);  // Each load follows its own fetch
    check_load(6, 32'h200, SZ_BYTE);
    check_load(10, 32'h201, SZ_BYTE);
    check_load(14, 32'h204, SZ_HALF);
    check_load(18, 32'h204, SZ_HALF);
    check_load(22, 32'h208, SZ_WORD);
  endtask

  task automatic test_narrow_store();
    start_test("narrow_store", 1'b0);
    prog.push_back(enc_addi(5'd1, 5'd0, 12'h280));
    prog.push_back(enc_addi(5'd2, 5'd0, 12'hEDC));         // -292
    prog.push_back(enc_store(F3_B, 5'd2, 5'd1, 12'd0));
    prog.push_back(enc_store(F3_H, 5'd2, 5'd1, 12'd2));
    prog.push_back(enc_store(F3_B, 5'd2, 5'd1, 12'hFFD));  // -3
    prog.push_back(enc_store(F3_W, 5'd2, 5'd1, 12'd4));
    run_program();
    check_eq("store count", 32'd4, 32'(stores.size()));
    check_store(0, 32'h280, SZ_BYTE, 32'h0000_00DC);
    check_store(1, 32'h282, SZ_HALF, 32'h0000_FEDC);
    check_store(2, 32'h27D, SZ_BYTE, 32'h0000_00DC);
    check_store(3, 32'h284, SZ_WORD, 32'hFFFF_FEDC);
  endtask

  task automatic test_random_delay();
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [11:0] off;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    start_test("random_delay", 1'b1);
    prog.push_back(enc_addi(5'd1, 5'd0, 12'h400));
    for (int i = 0; i < 6; i++) begin
      imm_a = 12'($urandom);
      imm_b = 12'($urandom);
      off   = 12'($urandom_range(255, 0)) - 12'd128;  // Offset in -128..127
      prog.push_back(enc_addi(5'd5, 5'd0, imm_a));
      prog.push_back(enc_addi(5'd6, 5'd5, imm_b));
      prog.push_back(enc_store(F3_W, 5'd6, 5'd1, off));
      exp_addr.push_back(32'h400 + sext12(off));
      exp_data.push_back(sext12(imm_a) + sext12(imm_b));
    end
    run_program();
    check_eq("store count", 32'd6, 32'(stores.size()));
    for (int i = 0; i < 6; i++) begin
      check_store(i, exp_addr[i], SZ_WORD, exp_data[i]);
    end
  endtask

  task automatic test_x0_and_unknown();
    start_test("x0_and_unknown", 1'b0);
    prog.push_back(enc_addi(5'd1, 5'd0, 12'h500));
    prog.push_back(enc_addi(5'd0, 5'd0, 12'd123));
    prog.push_back(32'h0000_006F);  // Jump encoding, not decoded
    prog.push_back(32'h00A0_8133);  // Register add, not decoded
    prog.push_back(enc_store(F3_W, 5'd0, 5'd1, 12'd0));
    prog.push_back(enc_store(F3_W, 5'd2, 5'd1, 12'd4));
    run_program();
    check_eq("fetch after unknown", 32'h10C, all_reqs[3].addr);
    check_eq("fetch after unknown write", 32'd0, 32'(all_reqs[3].write));
    check_eq("store count", 32'd2, 32'(stores.size()));
    check_store(0, 32'h500, SZ_WORD, 32'd0);
    check_store(1, 32'h504, SZ_WORD, 32'd0);  // x2 untouched by the add
  endtask

  initial begin
    int unsigned seed_init;
    arst_n     = 1'b0;
    rsp        = '0;
    end_pc     = '0;
    rand_delay = 1'b0;
    seed_init  = $urandom(55);
    test_fetch_sequence();
    test_addi_store();
    test_load_extend();
    test_narrow_store();
    test_random_delay();
    test_x0_and_unknown();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== rv_ls_core.f ====
hdl/mem_pkg.sv
hdl/isa_pkg.sv
hdl/insn_decoder.sv
hdl/reg_file.sv
hdl/load_store.sv
hdl/core_sequencer.sv
hdl/rv_ls_core.sv
test/tb_rv_ls_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
verilator --binary --assert --top-module tb_rv_ls_core -f rv_ls_core.f \
  && ./obj_dir/Vtb_rv_ls_core | grep "TESTS PASSED" \
  || { echo "Simulation did not pass"; exit 1; }
